//--- tests/dcache_stimulus.txt
# M <line address> <line, word 3 first>
# R|W|F <address> <read expected or write data> <byte enables> <0 hit 1 clean miss 2 dirty miss> <victim line>
M 00000040 00400003004000020040000100400000
M 00000180 01800003018000020180000101800000
M 00000020 00200003002000020020000100200000
M 00000120 01200003012000020120000101200000
M 00000220 02200003022000020220000102200000
M 00000320 03200003032000020320000103200000
M 00000420 04200003042000020420000104200000
M 00000520 05200003052000020520000105200000
# First reads miss, repeats hit
R 00000040 00400000 0 1 00000000
R 00000048 00400002 0 0 00000000
R 00000048 00400002 0 0 00000000
# Write-miss allocation then write hit
W 00000184 AABBCCDD 5 1 00000000
R 00000184 01BB00DD 0 0 00000000
W 00000184 11223344 A 0 00000000
R 00000184 11BB33DD 0 0 00000000
# Five tags in set 2, the first one dirty
W 00000020 CAFEF00D F 1 00000000
R 00000124 01200001 0 1 00000000
R 00000228 02200002 0 1 00000000
R 0000032C 03200003 0 1 00000000
R 00000420 04200000 0 2 00000020
R 00000520 05200000 0 1 00000000
R 00000020 CAFEF00D 0 1 00000000
R 00000024 00200001 0 0 00000000
# More dirty lines before the flush
W 00000044 DEADBEEF 3 0 00000000
R 00000044 0040BEEF 0 0 00000000
W 00000F00 12345678 F 1 00000000
R 00000F00 12345678 0 0 00000000
# Flush twice, lines stay resident
F 00000000 00000000 0 0 00000000
F 00000000 00000000 0 0 00000000
R 00000184 11BB33DD 0 0 00000000
R 00000044 0040BEEF 0 0 00000000

//--- sim.f
+incdir+src
src/dcache_pkg.sv
src/dcache_ctrl_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_fifo_repl.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module dcache_tb > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vdcache_tb > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "Result: fail"; exit 1; } \
    || { echo "Result: pass"; exit 0; }

//--- tests/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    localparam int TIMEOUT = 2000;       // Cycles allowed per wait

    logic  clk_i, rst_i;
    logic  p_strobe_i, p_rw_i, p_flush_i;
    addr_t p_addr_i;
    word_t p_data_i;
    be_t   p_byte_enable_i;
    word_t p_data_o;
    logic  p_ready_o, busy_flushing_o;
    logic  m_strobe_o, m_rw_o, m_ready_i;
    addr_t m_addr_o;
    line_t m_data_o, m_data_i;
    logic  pre_we;
    addr_t pre_addr;
    line_t pre_line;

    word_t golden [1024];                // Word-wide reference memory
    bit    dirty_lines [addr_t];         // Lines written since their last write-back
    logic  mem_rw_q [$];                 // Every memory request in issue order
    addr_t mem_addr_q [$];
    line_t mem_data_q [$];

    dcache_top dcache_top_inst (
        .clk_i, .rst_i, .p_strobe_i, .p_rw_i, .p_flush_i, .p_addr_i, .p_data_i,
        .p_byte_enable_i, .p_data_o, .p_ready_o, .m_strobe_o, .m_rw_o, .m_addr_o,
        .m_data_o, .m_data_i, .m_ready_i, .busy_flushing_o
    );

    dcache_mem_model mem_model_inst (
        .clk_i, .rst_i,
        .m_strobe_i(m_strobe_o), .m_rw_i(m_rw_o), .m_addr_i(m_addr_o), .m_data_i(m_data_o),
        .m_data_o(m_data_i), .m_ready_o(m_ready_i),
        .pre_we_i(pre_we), .pre_addr_i(pre_addr), .pre_line_i(pre_line)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;      // 100 ns period
    end

    always @(negedge clk_i)              // Log requests mid-cycle
    begin
        if (m_strobe_o)
        begin
            mem_rw_q.push_back(m_rw_o);
            mem_addr_q.push_back(m_addr_o);
            mem_data_q.push_back(m_data_o);
        end
    end

    // ==================================================================
    // Reference model and compare tasks
    // ==================================================================
    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;      // Untouched memory
    endfunction

    function automatic line_t golden_line(input addr_t a);
        return {golden[{a[11:4], 2'd3}], golden[{a[11:4], 2'd2}],
                golden[{a[11:4], 2'd1}], golden[{a[11:4], 2'd0}]};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input be_t be);
        word_t w;
        w = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                w[b * 8 +: 8] = data[b * 8 +: 8];   // Enabled bytes from the write
        return w;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
            report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp)
            report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic preload_line(input addr_t addr);
        pre_we   = 1'b1;
        pre_addr = addr;
        pre_line = golden_line(addr);
        @(posedge clk_i);
        #5;
        pre_we = 1'b0;
    endtask

    // ==================================================================
    // One processor command and its expected memory traffic
    // ==================================================================
    task automatic run_command(input logic [7:0] op, input addr_t addr, input word_t data,
                               input be_t be, input logic [3:0] kind, input addr_t victim);
        int    cycles;
        int    base;
        int    n_req;
        addr_t line_addr;
        string name;
        word_t rd_data;
        line_addr = {addr[31:4], 4'h0};
        name      = $sformatf("%c %h", op, addr);
        base      = mem_addr_q.size();
        if (op == "F")
            p_flush_i = 1'b1;
        else
        begin
            p_strobe_i      = 1'b1;
            p_rw_i          = (op == "W");
            p_addr_i        = addr;
            p_data_i        = data;
            p_byte_enable_i = be;
        end
        @(posedge clk_i);
        #5;
        p_strobe_i = 1'b0;
        p_flush_i  = 1'b0;
        cycles     = 1;
        while (!p_ready_o)
        begin
            if (op == "F" && !busy_flushing_o)
                report_failure($sformatf("%s busy_flushing_o low before p_ready_o", name));
            if (cycles >= TIMEOUT)
                report_failure($sformatf("%s no p_ready_o within %0d cycles", name, TIMEOUT));
            @(posedge clk_i);
            #5;
            cycles++;
        end
        if (op == "F" && busy_flushing_o)
            report_failure($sformatf("%s busy_flushing_o still high with p_ready_o", name));
        rd_data = p_data_o;              // Valid only in the ready cycle
        @(posedge clk_i);                // Next request only after the ready pulse
        #5;
        n_req = mem_addr_q.size() - base;
        if (op == "F")
        begin
            check_word({name, " write count"}, word_t'(dirty_lines.num()), word_t'(n_req));
            for (int i = base; i < base + n_req; i++)
            begin
                check_word({name, " rw"}, word_t'(1), word_t'(mem_rw_q[i]));
                if (!dirty_lines.exists(mem_addr_q[i]))
                    report_failure($sformatf("%s wrote back clean line %h", name, mem_addr_q[i]));
                check_line({name, " line data"}, golden_line(mem_addr_q[i]), mem_data_q[i]);
                dirty_lines.delete(mem_addr_q[i]);
            end
        end
        else
        begin
            if (kind == 4'd0)
                check_word({name, " hit latency"}, word_t'(1), word_t'(cycles));
            check_word({name, " request count"}, word_t'(kind), word_t'(n_req));
            if (kind == 4'd2)            // Dirty victim goes out first
            begin
                check_word({name, " eviction rw"}, word_t'(1), word_t'(mem_rw_q[base]));
                check_addr({name, " eviction addr"}, victim, mem_addr_q[base]);
                check_line({name, " eviction data"}, golden_line(victim), mem_data_q[base]);
                if (!dirty_lines.exists(victim))
                    report_failure($sformatf("%s evicted line %h was never written", name, victim));
                dirty_lines.delete(victim);
            end
            if (kind != 4'd0)            // Refill is the last request
            begin
                check_word({name, " refill rw"}, word_t'(0), word_t'(mem_rw_q[base + n_req - 1]));
                check_addr({name, " refill addr"}, line_addr, mem_addr_q[base + n_req - 1]);
            end
            if (op == "W")
            begin
                golden[addr[11:2]]     = merge_bytes(golden[addr[11:2]], data, be);
                dirty_lines[line_addr] = 1'b1;
            end
            else
            begin
                check_word({name, " file value"}, golden[addr[11:2]], data);
                check_word({name, " read data"}, golden[addr[11:2]], rd_data);
            end
        end
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial
    begin
        logic [7:0] op;
        logic [3:0] kind;
        int         fd;
        int         c;
        addr_t      addr;
        addr_t      victim;
        word_t      data;
        be_t        be;
        line_t      line;
        rst_i           = 1'b1;
        p_strobe_i      = 1'b0;
        p_rw_i          = 1'b0;
        p_flush_i       = 1'b0;
        p_addr_i        = '0;
        p_data_i        = '0;
        p_byte_enable_i = '0;
        pre_we          = 1'b0;
        pre_addr        = '0;
        pre_line        = '0;
        for (int i = 0; i < 1024; i++)
            golden[i] = fill_word(addr_t'(i * 4));
        repeat (16) @(posedge clk_i);
        #5;
        if (p_ready_o || m_strobe_o || m_rw_o || busy_flushing_o)
            report_failure("Handshake outputs not low during reset");
        rst_i = 1'b0;
        repeat (16) @(posedge clk_i);    // Init clears one set per cycle
        #5;
        for (int i = 0; i < 256; i++)
            preload_line(addr_t'(i * 16));
        fd = $fopen("tests/dcache_stimulus.txt", "r");
        if (fd == 0)
            report_failure("Cannot open tests/dcache_stimulus.txt");
        while ($fscanf(fd, " %c", op) == 1)
        begin
            if (op == "#")
            begin
                c = $fgetc(fd);
                while (c != 10 && c != -1)
                    c = $fgetc(fd);
            end
            else if (op == "M")
            begin
                if ($fscanf(fd, "%h %h", addr, line) != 2)
                    report_failure("Malformed memory line in the stimulus file");
                for (int w = 0; w < 4; w++)
                    golden[{addr[11:4], w[1:0]}] = line[w * 32 +: 32];
                preload_line(addr);
            end
            else
            begin
                if ($fscanf(fd, "%h %h %h %h %h", addr, data, be, kind, victim) != 5)
                    report_failure("Malformed command line in the stimulus file");
                run_command(op, addr, data, be, kind, victim);
            end
        end
        $fclose(fd);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model
    import dcache_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    input  wire logic  m_strobe_i,       // One-cycle request from the cache
    input  wire logic  m_rw_i,           // 1 = line write
    input  wire addr_t m_addr_i,
    input  wire line_t m_data_i,
    output line_t      m_data_o,
    output logic       m_ready_o,
    input  wire logic  pre_we_i,         // Preload port, one line per cycle
    input  wire addr_t pre_addr_i,
    input  wire line_t pre_line_i
);

    line_t      mem [256];               // 4 KB, indexed by addr[11:4]
    logic       busy_q;
    logic       rw_q;
    logic [7:0] idx_q;
    line_t      wdata_q;
    logic [3:0] wait_q;                  // Cycles left until m_ready_o
    logic [7:0] lfsr_q;

    // Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // ==================================================================
    // Request capture and delayed answer
    // ==================================================================
    always @(posedge clk_i)
    begin
        logic [7:0] s;
        logic [2:0] d;
        s = lfsr_q;
        for (int i = 0; i < 3; i++)
        begin
            s = lfsr_step(s);            // One step per delay bit
            d[i] = s[0];
        end
        if (rst_i)
        begin
            busy_q    <= 1'b0;
            m_ready_o <= 1'b0;
            m_data_o  <= '0;
            lfsr_q    <= 8'd82;          // Seed
        end
        else
        begin
            m_ready_o <= 1'b0;
            if (pre_we_i)
                mem[pre_addr_i[11:4]] <= pre_line_i;
            if (!busy_q && m_strobe_i)
            begin
                busy_q  <= 1'b1;
                rw_q    <= m_rw_i;
                idx_q   <= m_addr_i[11:4];
                wdata_q <= m_data_i;
                wait_q  <= {1'b0, d} + 4'd1;   // 1 to 8 cycles
                lfsr_q  <= s;
            end
            else if (busy_q)
            begin
                if (wait_q != 4'd1)
                    wait_q <= wait_q - 4'd1;
                else
                begin
                    busy_q    <= 1'b0;
                    m_ready_o <= 1'b1;       // Single pulse
                    if (rw_q)
                        mem[idx_q] <= wdata_q;
                    else
                        m_data_o <= mem[idx_q];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    // Processor side
    input  wire logic  p_strobe_i,
    input  wire logic  p_rw_i,            // 1 = write
    input  wire logic  p_flush_i,
    input  wire addr_t p_addr_i,
    input  wire word_t p_data_i,
    input  wire be_t   p_byte_enable_i,
    output word_t      p_data_o,
    output logic       p_ready_o,
    // Memory side, whole lines
    output logic       m_strobe_o,
    output logic       m_rw_o,
    output addr_t      m_addr_o,
    output line_t      m_data_o,
    input  wire line_t m_data_i,
    input  wire logic  m_ready_i,
    output logic       busy_flushing_o
);

    set_t    set;          // Common set address of all storage
    tag_t    tag;
    way_t    act_way;
    offset_t offset;
    word_t   wdata;
    be_t     be;
    wr_src_t wr_src;
    logic    fill, mark_dirty, clean, clear, advance;
    logic    hit;
    way_t    hit_way, victim;
    tag_t    sel_tag;
    logic    sel_dirty;

    dcache_ctrl u_ctrl (
        .clk_i, .rst_i,
        .p_strobe_i, .p_rw_i, .p_flush_i, .p_addr_i, .p_data_i, .p_byte_enable_i,
        .m_ready_i,
        .hit_i(hit), .hit_way_i(hit_way), .victim_i(victim),
        .sel_tag_i(sel_tag), .sel_dirty_i(sel_dirty),
        .set_o(set), .tag_o(tag), .act_way_o(act_way),
        .offset_o(offset), .wdata_o(wdata), .be_o(be), .wr_src_o(wr_src),
        .fill_o(fill), .mark_dirty_o(mark_dirty), .clean_o(clean),
        .clear_o(clear), .advance_o(advance),
        .p_ready_o, .m_strobe_o, .m_rw_o, .m_addr_o, .busy_flushing_o
    );

    dcache_tag_array u_tag_array (
        .clk_i,
        .set_i(set), .tag_i(tag), .act_way_i(act_way),
        .fill_i(fill), .mark_dirty_i(mark_dirty), .clean_i(clean), .clear_i(clear),
        .hit_o(hit), .hit_way_o(hit_way), .sel_tag_o(sel_tag), .sel_dirty_o(sel_dirty)
    );

    dcache_data_array u_data_array (
        .clk_i,
        .set_i(set), .act_way_i(act_way), .offset_i(offset),
        .wdata_i(wdata), .be_i(be), .wr_src_i(wr_src),
        .m_data_i, .m_ready_i,
        .rd_word_o(p_data_o),       // Read answer straight from the array
        .sel_line_o(m_data_o)       // Write-back payload
    );

    dcache_fifo_repl u_fifo_repl (
        .clk_i, .rst_i,
        .set_i(set), .advance_i(advance), .victim_o(victim)
    );

endmodule

`default_nettype wire

//--- src/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl
    import dcache_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    input  wire logic  p_strobe_i,
    input  wire logic  p_rw_i,
    input  wire logic  p_flush_i,
    input  wire addr_t p_addr_i,
    input  wire word_t p_data_i,
    input  wire be_t   p_byte_enable_i,
    input  wire logic  m_ready_i,
    input  wire logic  hit_i,
    input  wire way_t  hit_way_i,
    input  wire way_t  victim_i,
    input  wire tag_t  sel_tag_i,         // Tag of act_way_o
    input  wire logic  sel_dirty_i,       // Dirty bit of act_way_o
    output set_t       set_o,
    output tag_t       tag_o,
    output way_t       act_way_o,
    output offset_t    offset_o,
    output word_t      wdata_o,
    output be_t        be_o,
    output wr_src_t    wr_src_o,
    output logic       fill_o, mark_dirty_o, clean_o, clear_o, advance_o,
    output logic       p_ready_o,
    output logic       m_strobe_o,
    output logic       m_rw_o,
    output addr_t      m_addr_o,
    output logic       busy_flushing_o
);

    localparam int LO = `DC_BYTE_BITS + `DC_OFFSET_BITS;   // Lowest set bit
    localparam int FC = `DC_SET_BITS + `DC_WAY_BITS;       // Flush counter width

    state_t        state_q, state_d;
    set_t          init_cnt_q;
    logic [FC-1:0] flush_cnt_q;          // {set, way}, way runs fastest
    addr_t         req_addr_q;
    logic          req_rw_q;
    word_t         req_data_q;
    be_t           req_be_q;
    logic          flushing, flush_last, flush_done, ana_hit, mem_enter;

    // ==================================================================
    // Request capture, payload only
    // ==================================================================
    always_ff @(posedge clk_i)
    begin
        if (state_q == S_IDLE && p_strobe_i)
        begin
            req_addr_q <= p_addr_i;
            req_rw_q   <= p_rw_i;
            req_data_q <= p_data_i;
            req_be_q   <= p_byte_enable_i;
        end
    end

    assign flushing   = (state_q == S_FLUSH_NEXT) || (state_q == S_FLUSH_WB);
    assign flush_last = &flush_cnt_q;                       // Set 15, way 3
    assign flush_done = (state_q == S_FLUSH_NEXT) && !sel_dirty_i && flush_last;
    assign ana_hit    = (state_q == S_ANALYSIS) && hit_i;

    // ==================================================================
    // State machine
    // ==================================================================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_INIT:       if (init_cnt_q == set_t'(`DC_N_SETS - 1)) state_d = S_IDLE;
            S_IDLE:
            begin
                if (p_flush_i)
                    state_d = S_FLUSH_NEXT;
                else if (p_strobe_i)
                    state_d = S_ANALYSIS;
            end
            S_ANALYSIS:                            // act_way_o is the victim on a miss
            begin
                if (hit_i)
                    state_d = S_IDLE;
                else
                    state_d = sel_dirty_i ? S_WB : S_RD;
            end
            S_WB:         if (m_ready_i) state_d = S_WB_DONE;
            S_WB_DONE:    state_d = S_RD;
            S_RD:         if (m_ready_i) state_d = S_RD_DONE;
            S_RD_DONE:    state_d = S_IDLE;
            S_FLUSH_NEXT:
            begin
                if (sel_dirty_i)
                    state_d = S_FLUSH_WB;
                else if (flush_last)
                    state_d = S_IDLE;
            end
            S_FLUSH_WB:   if (m_ready_i) state_d = S_FLUSH_NEXT; // Same pair, now clean
            default:      state_d = S_IDLE;
        endcase
    end

    // Strobe goes out in the first cycle of each memory wait
    assign mem_enter = (state_d != state_q) &&
                       (state_d == S_WB || state_d == S_RD || state_d == S_FLUSH_WB);

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q     <= S_INIT;
            init_cnt_q  <= '0;
            flush_cnt_q <= '0;
            m_strobe_o  <= 1'b0;
        end
        else
        begin
            state_q    <= state_d;
            m_strobe_o <= mem_enter;
            if (state_q == S_INIT)
                init_cnt_q <= init_cnt_q + 1'b1;
            if (state_q == S_FLUSH_NEXT && !sel_dirty_i)
                flush_cnt_q <= flush_cnt_q + 1'b1;       // Wraps to 0 after the last pair
        end
    end

    // ==================================================================
    // Storage addressing and write controls
    // ==================================================================
    always_comb
    begin
        if (state_q == S_INIT)
            set_o = init_cnt_q;
        else if (flushing)
            set_o = flush_cnt_q[FC-1:`DC_WAY_BITS];
        else
            set_o = req_addr_q[LO +: `DC_SET_BITS];
    end

    assign tag_o     = req_addr_q[`DC_XLEN-1 -: `DC_TAG_BITS];
    assign act_way_o = flushing ? flush_cnt_q[`DC_WAY_BITS-1:0] : (hit_i ? hit_way_i : victim_i);
    assign offset_o  = req_addr_q[`DC_BYTE_BITS +: `DC_OFFSET_BITS];
    assign wdata_o   = req_data_q;
    assign be_o      = req_rw_q ? req_be_q : '0;             // Reads merge nothing

    always_comb
    begin
        if (ana_hit && req_rw_q)
            wr_src_o = WR_HIT_MERGE;
        else if (state_q == S_RD_DONE)
            wr_src_o = WR_REFILL;
        else
            wr_src_o = WR_NONE;
    end

    assign fill_o       = (state_q == S_RD_DONE);
    assign mark_dirty_o = req_rw_q && (ana_hit || state_q == S_RD_DONE); // Fill dirty = rw
    assign clean_o      = (state_q == S_FLUSH_WB) && m_ready_i;
    assign clear_o      = (state_q == S_INIT);
    assign advance_o    = (state_q == S_RD_DONE);

    // ==================================================================
    // Handshake outputs
    // ==================================================================
    assign p_ready_o       = ana_hit || (state_q == S_RD_DONE) || flush_done;
    assign busy_flushing_o = flushing && !flush_done;
    assign m_rw_o          = (state_q == S_WB) || (state_q == S_FLUSH_WB);
    assign m_addr_o        = {(state_q == S_RD) ? tag_o : sel_tag_i, set_o, {LO{1'b0}}};

endmodule

`default_nettype wire

//--- src/dcache_fifo_repl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_fifo_repl
    import dcache_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire set_t set_i,
    input  wire logic advance_i,        // One refill installed in set_i
    output way_t      victim_o
);

    way_t ptr_q [`DC_N_SETS];           // Next way to replace, per set

    assign victim_o = ptr_q[set_i];

    // Round robin 0, 1, 2, 3, 0 ... in each set
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `DC_N_SETS; s++)
                ptr_q[s] <= '0;
        end
        else if (advance_i)
            ptr_q[set_i] <= ptr_q[set_i] + 1'b1;
    end

endmodule

`default_nettype wire

//--- src/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_data_array
    import dcache_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  wire logic    clk_i,
    input  wire set_t    set_i,
    input  wire way_t    act_way_i,
    input  wire offset_t offset_i,      // Word within the line
    input  wire word_t   wdata_i,
    input  wire be_t     be_i,
    input  wire wr_src_t wr_src_i,
    input  wire line_t   m_data_i,
    input  wire logic    m_ready_i,
    output word_t        rd_word_o,     // Addressed word, merge applied
    output line_t        sel_line_o     // Stored line of the active way
);

    localparam int W = `DC_XLEN;

    line_t line_q [`DC_N_WAYS][`DC_N_SETS];
    line_t refill_q;                    // Line returned by memory
    line_t base_line;
    line_t merged_line;

    // Refill line held until the install cycle
    always_ff @(posedge clk_i)
    begin
        if (m_ready_i)
            refill_q <= m_data_i;
    end

    assign sel_line_o = line_q[act_way_i][set_i];
    assign base_line  = (wr_src_i == WR_REFILL) ? refill_q : sel_line_o;

    // ==================================================================
    // Byte merge into the addressed word
    // ==================================================================
    always_comb
    begin
        merged_line = base_line;
        for (int b = 0; b < W / 8; b++)
        begin
            if (be_i[b])
                merged_line[offset_i * W + b * 8 +: 8] = wdata_i[b * 8 +: 8];
        end
    end

    // Word extraction, word 0 in the low bits
    assign rd_word_o = merged_line[offset_i * W +: W];

    // ==================================================================
    // Line storage
    // ==================================================================
    always_ff @(posedge clk_i)
    begin
        if (wr_src_i != WR_NONE)
            line_q[act_way_i][set_i] <= merged_line;    // Write hit or refill install
    end

endmodule

`default_nettype wire

//--- src/dcache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tag_array
    import dcache_pkg::*;
(
    input  wire logic clk_i,
    input  wire set_t set_i,
    input  wire tag_t tag_i,
    input  wire way_t act_way_i,
    input  wire logic fill_i,           // Install tag, valid, dirty = mark_dirty_i
    input  wire logic mark_dirty_i,
    input  wire logic clean_i,
    input  wire logic clear_i,          // Whole set invalid and clean
    output logic      hit_o,
    output way_t      hit_way_o,
    output tag_t      sel_tag_o,
    output logic      sel_dirty_o
);

    tag_t                   tag_q   [`DC_N_WAYS][`DC_N_SETS];
    logic [`DC_N_WAYS-1:0]  valid_q [`DC_N_SETS];  // One bit per way
    logic [`DC_N_WAYS-1:0]  dirty_q [`DC_N_SETS];
    logic [`DC_N_WAYS-1:0]  way_hit;

    // ==================================================================
    // Lookup, all ways in parallel
    // ==================================================================
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < `DC_N_WAYS; w++)
        begin
            way_hit[w] = valid_q[set_i][w] && (tag_q[w][set_i] == tag_i);
            if (way_hit[w])
                hit_way_o = way_t'(w);   // At most one way matches
        end
    end

    assign hit_o       = |way_hit;
    assign sel_tag_o   = tag_q[act_way_i][set_i];     // Eviction / flush address
    assign sel_dirty_o = dirty_q[set_i][act_way_i];

    // ==================================================================
    // Updates
    // ==================================================================
    always_ff @(posedge clk_i)
    begin
        if (clear_i)
        begin
            valid_q[set_i] <= '0;
            dirty_q[set_i] <= '0;
        end
        else if (fill_i)
        begin
            tag_q[act_way_i][set_i]   <= tag_i;
            valid_q[set_i][act_way_i] <= 1'b1;
            dirty_q[set_i][act_way_i] <= mark_dirty_i;  // Write miss allocates dirty
        end
        else if (mark_dirty_i)
            dirty_q[set_i][act_way_i] <= 1'b1;          // Write hit
        else if (clean_i)
            dirty_q[set_i][act_way_i] <= 1'b0;          // Flush write-back accepted
    end

endmodule

`default_nettype wire

//--- src/dcache_ctrl_pkg.sv
`default_nettype none

// Controller encodings
package dcache_ctrl_pkg;

    typedef enum logic [3:0] {
        S_INIT,          // Clearing valid/dirty, one set per cycle
        S_IDLE,
        S_ANALYSIS,      // Hit check on the captured request
        S_WB,            // Victim write-back in flight
        S_WB_DONE,
        S_RD,            // Line refill in flight
        S_RD_DONE,       // Install refill, answer processor
        S_FLUSH_WB,      // Flush write-back in flight
        S_FLUSH_NEXT     // Flush scan of one set/way pair
    } state_t;

    // What the data array writes into the active way
    typedef enum logic [1:0] {
        WR_NONE,
        WR_HIT_MERGE,    // Stored line with bytes merged in
        WR_REFILL        // Captured refill with bytes merged in
    } wr_src_t;

endpackage

`default_nettype wire

//--- src/dcache_pkg.sv
`default_nettype none

`include "dcache_defs.svh"

// Vector types shared by the cache datapath
package dcache_pkg;

    typedef logic [`DC_XLEN-1:0]        addr_t;    // Byte address
    typedef logic [`DC_XLEN-1:0]        word_t;    // Processor data word
    typedef logic [`DC_LINE_BITS-1:0]   line_t;    // Word 0 in the low bits

    // Address fields
    typedef logic [`DC_TAG_BITS-1:0]    tag_t;
    typedef logic [`DC_SET_BITS-1:0]    set_t;
    typedef logic [`DC_OFFSET_BITS-1:0] offset_t;

    typedef logic [`DC_WAY_BITS-1:0]    way_t;     // Way number
    typedef logic [`DC_XLEN/8-1:0]      be_t;      // One enable per byte

endpackage

`default_nettype wire

//--- src/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ======================================================================
// Cache geometry
// ======================================================================
`define DC_XLEN            32    // Processor word
`define DC_LINE_BITS       128   // One cache line
`define DC_N_WAYS          4
`define DC_N_SETS          16
`define DC_WORDS_PER_LINE  4

// Address split: | tag | set | word offset | byte |
`define DC_OFFSET_BITS     2     // Word within a line
`define DC_BYTE_BITS       2     // Byte within a word
`define DC_SET_BITS        4
`define DC_WAY_BITS        2
`define DC_TAG_BITS        24    // XLEN - SET - OFFSET - BYTE

`endif
